// ==== rvPkg.sv ====
package rvPkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5; // Register index width.

    typedef enum logic [6:0] {
        R_T    = 7'b0110011,
        I_T    = 7'b0010011,
        S_T    = 7'b0100011,
        B_T    = 7'b1100011,
        U_T    = 7'b0110111,
        J_T    = 7'b1101111,
        LW_T   = 7'b0000011,
        JALR_T = 7'b1100111
    } opcodeE;

    typedef enum logic [4:0] {
        IF   = 5'b00000,
        ID   = 5'b00001,
        EX1  = 5'b00010,
        EX2  = 5'b00011,
        EX3  = 5'b00100,
        EX4  = 5'b00101,
        EX5  = 5'b00110,
        EX6  = 5'b00111,
        EX7  = 5'b01000,
        EX8  = 5'b01001,
        EX9  = 5'b01010,
        MEM1 = 5'b01011,
        MEM2 = 5'b01100,
        MEM3 = 5'b01101,
        MEM4 = 5'b01110,
        MEM5 = 5'b01111,
        MEM6 = 5'b10000,
        WB   = 5'b10001
    } ctrlStateE;

    typedef enum logic [1:0] {aluAdd, aluSub, aluFunct, aluImmFunct} aluOpE;
    typedef enum logic [1:0] {srcPc, srcOldPc, srcReg} srcAE;
    typedef enum logic [1:0] {srcBReg, srcBImm, srcBFour} srcBE;

    // resAlu is the aluOut register, resAluOut the live ALU output.
    typedef enum logic [1:0] {resAlu, resData, resAluOut, resImm} resultE;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immE;

endpackage

// ==== memBus.sv ====
`timescale 1ns/1ps

interface memBus import rvPkg::*; ();

    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic            we;

    modport core (
        output addr, wdata, we,
        input  rdata
    );

    modport mem (
        input  addr, wdata, we,
        output rdata
    );

endinterface

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  aluOpE           aluOp,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y,
    output logic            zero,
    output logic            neg
);

    typedef enum logic [2:0] {opAdd, opSub, opAnd, opOr, opSlt} aluCtlE;

    aluCtlE          ctl;
    logic [XLEN-1:0] diff;
    logic            lessThan;

    always_comb begin
        ctl = opAdd;
        case (aluOp)
            aluAdd: ctl = opAdd;
            aluSub: ctl = opSub;
            default: begin
                case (funct3)
                    3'b000: ctl = (aluOp == aluFunct && funct7b5) ? opSub : opAdd;
                    3'b010: ctl = opSlt;
                    3'b110: ctl = opOr;
                    3'b111: ctl = opAnd;
                    default: ctl = opAdd;
                endcase
            end
        endcase
    end

    assign diff = a - b;

    // Signs differ, so the negative operand is the smaller one.
    assign lessThan = (a[XLEN-1] ^ b[XLEN-1]) ? a[XLEN-1] : diff[XLEN-1];

    always_comb begin
        case (ctl)
            opSub:   y = diff;
            opAnd:   y = a & b;
            opOr:    y = a | b;
            opSlt:   y = {{(XLEN-1){1'b0}}, lessThan};
            default: y = a + b;
        endcase
    end

    assign zero = (y == '0);
    assign neg  = lessThan; // Signed a < b.

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile import rvPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  logic [REG_AW-1:0] ra1,
    input  logic [REG_AW-1:0] ra2,
    input  logic [REG_AW-1:0] wa,
    input  logic [XLEN-1:0]   wd,
    output logic [XLEN-1:0]   rd1,
    output logic [XLEN-1:0]   rd2
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin // x0 stays zero.
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// ==== mainController.sv ====
`timescale 1ns/1ps

module mainController import rvPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  opcodeE    op,
    input  logic      zero,
    input  logic      neg,
    output logic      pcUpdate,
    output logic      adrSrc,
    output logic      memWrite,
    output logic      branch,
    output logic      irWrite,
    output logic      regWrite,
    output resultE    resultSrc,
    output aluOpE     aluOp,
    output srcAE      aluSrcA,
    output srcBE      aluSrcB,
    output immE       immSrc
);

    ctrlStateE state;
    ctrlStateE nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= IF;
        else
            state <= nextState;
    end

    always_comb begin
        nextState = IF;
        case (state)
            IF: nextState = ID;
            ID: begin
                case (op)
                    R_T:     nextState = EX2;
                    I_T:     nextState = EX1;
                    S_T:     nextState = EX6;
                    J_T:     nextState = EX4;
                    B_T:     nextState = EX3;
                    U_T:     nextState = MEM5;
                    LW_T:    nextState = EX9;
                    JALR_T:  nextState = EX8;
                    default: nextState = IF; // Unknown opcode.
                endcase
            end
            EX1:  nextState = MEM2;
            EX2:  nextState = MEM4;
            EX4:  nextState = EX7;
            EX5:  nextState = MEM2;
            EX6:  nextState = MEM3;
            EX7:  nextState = MEM6;
            EX8:  nextState = EX5;
            EX9:  nextState = MEM1;
            MEM1: nextState = WB;
            default: nextState = IF;
        endcase
    end

    always_comb begin
        pcUpdate  = 1'b0;
        adrSrc    = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        irWrite   = 1'b0;
        regWrite  = 1'b0;
        resultSrc = resAlu;
        aluOp     = aluAdd;
        aluSrcA   = srcPc;
        aluSrcB   = srcBReg;
        immSrc    = immI;
        case (state)
            IF: begin // PC + 4 straight back into PC.
                irWrite   = 1'b1;
                aluSrcB   = srcBFour;
                resultSrc = resAluOut;
                pcUpdate  = 1'b1;
            end
            ID: begin // Branch target ahead of time.
                aluSrcA = srcOldPc;
                aluSrcB = srcBImm;
                immSrc  = immB;
            end
            EX1: begin
                aluSrcA = srcReg;
                aluSrcB = srcBImm;
                aluOp   = aluImmFunct;
            end
            EX2: begin
                aluSrcA = srcReg;
                aluOp   = aluFunct;
            end
            EX3: begin
                aluSrcA = srcReg;
                aluOp   = aluSub;
                branch  = 1'b1;
            end
            EX4: begin // Return address.
                aluSrcA = srcOldPc;
                aluSrcB = srcBFour;
            end
            EX5: begin
                aluSrcA  = srcOldPc;
                aluSrcB  = srcBFour;
                pcUpdate = 1'b1;
            end
            EX6: begin
                aluSrcA = srcReg;
                aluSrcB = srcBImm;
                immSrc  = immS;
            end
            EX7: begin
                regWrite = 1'b1;
                aluSrcA  = srcOldPc; // Jump target from old PC.
                aluSrcB  = srcBImm;
                immSrc   = immJ;
            end
            EX8, EX9: begin
                aluSrcA = srcReg;
                aluSrcB = srcBImm;
            end
            MEM1: adrSrc = 1'b1;
            MEM2, MEM4: regWrite = 1'b1;
            MEM3: begin
                adrSrc   = 1'b1;
                memWrite = 1'b1;
            end
            MEM5: begin
                resultSrc = resImm;
                immSrc    = immU;
                regWrite  = 1'b1;
            end
            MEM6: pcUpdate = 1'b1;
            WB: begin
                resultSrc = resData;
                regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    pcUpdate,
    input  logic    adrSrc,
    input  logic    irWrite,
    input  logic    regWrite,
    input  logic    branch,
    input  resultE  resultSrc,
    input  srcAE    aluSrcA,
    input  srcBE    aluSrcB,
    input  aluOpE   aluOp,
    input  immE     immSrc,
    output opcodeE  op,
    output logic    zero,
    output logic    neg,
    memBus.core     bus
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] oldPc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] dataReg;
    logic [XLEN-1:0] aReg;
    logic [XLEN-1:0] bReg;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] result;
    logic            taken;
    logic            pcWrite;

    always_comb begin
        case (instr[14:12])
            3'b000:  taken = zero;  // beq
            3'b001:  taken = !zero; // bne
            3'b100:  taken = neg;   // blt
            3'b101:  taken = !neg;  // bge
            default: taken = 1'b0;
        endcase
    end

    assign pcWrite = pcUpdate | (branch & taken);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= '0;
        else if (pcWrite)
            pc <= result;
    end

    // Instruction and its PC are captured together.
    always_ff @(posedge clk) begin
        if (irWrite) begin
            instr <= bus.rdata;
            oldPc <= pc;
        end
        dataReg <= bus.rdata;
        aReg    <= rd1;
        bReg    <= rd2;
        aluOut  <= aluResult;
    end

    assign op = opcodeE'(instr[6:0]);

    registerFile regFile (
        .clk (clk),
        .rst (rst),
        .we  (regWrite),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (immSrc)
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0};
            immJ:    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        case (aluSrcA)
            srcOldPc: srcA = oldPc;
            srcReg:   srcA = aReg;
            default:  srcA = pc;
        endcase
        case (aluSrcB)
            srcBImm:  srcB = immExt;
            srcBFour: srcB = 32'd4;
            default:  srcB = bReg;
        endcase
    end

    alu aluUnit (
        .aluOp    (aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .a        (srcA),
        .b        (srcB),
        .y        (aluResult),
        .zero     (zero),
        .neg      (neg)
    );

    always_comb begin
        case (resultSrc)
            resData:   result = dataReg;
            resAluOut: result = aluResult;
            resImm:    result = immExt;
            default:   result = aluOut;
        endcase
    end

    assign bus.addr  = adrSrc ? result : pc;
    assign bus.wdata = bReg; // rs2 for sw.

endmodule

// ==== unifiedMemory.sv ====
`timescale 1ns/1ps

module unifiedMemory import rvPkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         loadWe,
    input  logic [$clog2(MEM_WORDS)-1:0] loadAddr,
    input  logic [XLEN-1:0]              loadData,
    output logic                         storeValid,
    output logic [XLEN-1:0]              storeAddr,
    output logic [XLEN-1:0]              storeData,
    memBus.mem                           bus
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [ADDR_W-1:0] coreIdx;
    logic              coreGrant;

    assign coreIdx = bus.addr[ADDR_W+1:2]; // Byte to word address.

    // Loader has fixed priority.
    assign coreGrant = bus.we & ~loadWe;

    always_ff @(posedge clk) begin
        if (loadWe)
            mem[loadAddr] <= loadData;
        else if (coreGrant)
            mem[coreIdx] <= bus.wdata;
    end

    assign bus.rdata = mem[coreIdx];

    assign storeValid = coreGrant;
    assign storeAddr  = bus.addr;
    assign storeData  = bus.wdata;

endmodule

// ==== riscvTop.sv ====
`timescale 1ns/1ps

module riscvTop import rvPkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         loadWe,
    input  logic [$clog2(MEM_WORDS)-1:0] loadAddr,
    input  logic [XLEN-1:0]              loadData,
    output logic                         storeValid,
    output logic [XLEN-1:0]              storeAddr,
    output logic [XLEN-1:0]              storeData
);

    logic   pcUpdate;
    logic   adrSrc;
    logic   memWrite;
    logic   branch;
    logic   irWrite;
    logic   regWrite;
    logic   zero;
    logic   neg;
    opcodeE op;
    resultE resultSrc;
    aluOpE  aluOp;
    srcAE   aluSrcA;
    srcBE   aluSrcB;
    immE    immSrc;

    memBus bus ();

    assign bus.we = memWrite; // Write strobe comes from the FSM.

    mainController ctrl (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .zero      (zero),
        .neg       (neg),
        .pcUpdate  (pcUpdate),
        .adrSrc    (adrSrc),
        .memWrite  (memWrite),
        .branch    (branch),
        .irWrite   (irWrite),
        .regWrite  (regWrite),
        .resultSrc (resultSrc),
        .aluOp     (aluOp),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .immSrc    (immSrc)
    );

    datapath dp (
        .clk       (clk),
        .rst       (rst),
        .pcUpdate  (pcUpdate),
        .adrSrc    (adrSrc),
        .irWrite   (irWrite),
        .regWrite  (regWrite),
        .branch    (branch),
        .resultSrc (resultSrc),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .aluOp     (aluOp),
        .immSrc    (immSrc),
        .op        (op),
        .zero      (zero),
        .neg       (neg),
        .bus       (bus)
    );

    unifiedMemory #(
        .MEM_WORDS (MEM_WORDS)
    ) memory (
        .clk        (clk),
        .loadWe     (loadWe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .bus        (bus)
    );

endmodule

// ==== ctrl_assertions.sv ====
`timescale 1ns/1ps

module ctrlAssertions import rvPkg::*; (
    input logic      clk,
    input logic      rst,
    input ctrlStateE state,
    input logic      zero,
    input logic      neg,
    input logic      memWrite,
    input logic      regWrite,
    input logic      adrSrc
);

    int failCount = 0;

    noWriteOverlap: assert property (@(posedge clk) disable iff (rst)
        !(memWrite && regWrite))
        else begin
            $error("memWrite and regWrite are high in the same cycle");
            failCount++;
        end

    // Stores must use the data address.
    writeUsesDataAddr: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> adrSrc)
        else begin
            $error("memWrite is high while adrSrc selects the PC");
            failCount++;
        end

    fetchThenDecode: assert property (@(posedge clk) disable iff (rst)
        state == IF |=> state == ID)
        else begin
            $error("state after IF is not ID");
            failCount++;
        end

    // Equal operands never compare as less.
    branchFlags: assert property (@(posedge clk) disable iff (rst)
        (state == EX3 && zero) |-> !neg)
        else begin
            $error("zero and neg are both high in the branch state");
            failCount++;
        end

endmodule

// ==== riscvTb.sv ====
`timescale 1ns/1ps

module riscvTb import rvPkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int AW = $clog2(MEM_WORDS);

    logic            clk;
    logic            rst;
    logic            loadWe;
    logic [AW-1:0]   loadAddr;
    logic [XLEN-1:0] loadData;
    logic            storeValid;
    logic [XLEN-1:0] storeAddr;
    logic [XLEN-1:0] storeData;

    logic [XLEN-1:0] progWords [$];
    logic [XLEN-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];
    int              loopCount = 1;
    int              cycleLimit = 0;
    int              cycles = 0;
    int              storeIdx = 0;
    bit              running = 1'b0;

    riscvTop #(
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .loadWe     (loadWe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    bind mainController ctrlAssertions checks (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .zero     (zero),
        .neg      (neg),
        .memWrite (memWrite),
        .regWrite (regWrite),
        .adrSrc   (adrSrc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Tagged sections, comment lines start with a lone #.
    task automatic readCases();
        int              fd;
        int              n;
        int              count;
        int              bad;
        logic [7:0]      tag;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        logic [8*160-1:0] rest;
        bad = 0;
        fd = $fopen("riscvCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file riscvCases.txt");
            $display("TEST FAILED");
            $fatal(1, "Case file missing");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "L") begin
                n = $fscanf(fd, "%d", loopCount);
                if (n != 1)
                    bad++;
            end else if (tag == "P") begin
                n = $fscanf(fd, "%d", count);
                if (n != 1)
                    bad++;
                for (int j = 0; j < count; j++) begin
                    n = $fscanf(fd, "%h", a);
                    if (n != 1)
                        bad++;
                    progWords.push_back(a);
                end
            end else if (tag == "S") begin
                n = $fscanf(fd, "%d", count);
                if (n != 1)
                    bad++;
                for (int j = 0; j < count; j++) begin
                    n = $fscanf(fd, "%h %h", a, d);
                    if (n != 2)
                        bad++;
                    expAddr.push_back(a);
                    expData.push_back(d);
                end
            end else begin
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        if (bad != 0 || progWords.size() == 0 || expAddr.size() == 0) begin
            $display("The case file riscvCases.txt is malformed or holds no program or stores");
            $display("TEST FAILED");
            $fatal(1, "Bad case file");
        end
    endtask

    task automatic checkValue(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s = %h, expected %h", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic waitStore();
        do
            @(negedge clk);
        while (storeValid !== 1'b1);
    endtask

    always @(posedge clk) begin
        if (running) begin
            if (cycles >= cycleLimit) begin
                $display("Timeout after %0d cycles while waiting for store %0d of %0d",
                         cycles, storeIdx + 1, expAddr.size());
                $display("TEST FAILED");
                $fatal(1, "Timeout");
            end else begin
                cycles <= cycles + 1;
            end
        end
    end

    // Stop at the first controller assertion failure.
    always @(negedge clk) begin
        if (dut.ctrl.checks.failCount != 0) begin
            $display("A controller assertion failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        rst      = 1'b1;
        loadWe   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        readCases();
        cycleLimit = progWords.size() * 5 * loopCount + 100;

        // Program goes in while the core is held in reset.
        for (int i = 0; i < progWords.size(); i++) begin
            @(posedge clk);
            loadWe   <= 1'b1;
            loadAddr <= AW'(i);
            loadData <= progWords[i];
        end
        @(posedge clk);
        loadWe <= 1'b0;
        repeat (10) @(posedge clk); // Ten more reset cycles.
        rst     <= 1'b0;
        running <= 1'b1;

        for (storeIdx = 0; storeIdx < expAddr.size(); storeIdx++) begin
            waitStore();
            checkValue("storeAddr", storeAddr, expAddr[storeIdx]);
            checkValue("storeData", storeData, expData[storeIdx]);
        end

        if (dut.ctrl.checks.failCount == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Controller assertions failed %0d times", dut.ctrl.checks.failCount);
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// ==== riscvCases.txt ====
# L n: loop passes for the timeout; P n: n program words (hex) from word address 0
# S n: n expected stores in order, byte address then data (hex)
L 3
P 54
20000513 03500093 FF900113 002081B3 40208233 0020F2B3
0020E333 001123B3 00352023 00452223 00552423 00652623
00752823 00F0F193 40C0E213 FFD12293 ABCDE337 00108013
00352A23 00452C23 00552E23 02652023 02052223 02850593
FE45A603 02052683 00C5A023 00D5A223 00300713 00E5A423
00458593 FFF70713 FE071AE3 07700793 00208463 00F5A423
00108463 0015A423 00114463 0025A423 0020C463 00F5A623
00115463 0015A823 0020D463 0025A823 0080086F 0025AA23
0105AA23 0CC00893 00488967 0025AC23 0125AC23 0000006F
S 20
00000200 0000002E
00000204 0000003C
00000208 00000031
0000020C FFFFFFFD
00000210 00000001
00000214 00000005
00000218 0000043D
0000021C 00000001
00000220 ABCDE000
00000224 00000000
00000228 FFFFFFFD
0000022C ABCDE000
00000230 00000003
00000234 00000002
00000238 00000001
0000023C 00000077
00000240 00000077
00000244 00000035
00000248 000000BC
0000024C 000000CC

// ==== vlog.f ====
rvPkg.sv
memBus.sv
alu.sv
registerFile.sv
mainController.sv
datapath.sv
unifiedMemory.sv
riscvTop.sv
ctrl_assertions.sv
riscvTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --assert --top-module riscvTb -f vlog.f -o simRiscv \
    && ./obj_dir/simRiscv +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "TEST PASSED" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
